//--- tti_pkg.sv
// Shared widths, register map and threshold register layout of the TTI block.
// Modules import it inside their body and use scoped names in their port lists.
package tti_pkg;

  // Register bus and queue word width
  localparam int unsigned TtiDataWidth = 32;

  // One threshold field of the threshold control register
  localparam int unsigned TtiThldWidth = 8;

  localparam int unsigned TtiAddrWidth = 3;

  // Number of used bits in the status register, the rest read as zero
  localparam int unsigned TtiStatusWidth = 14;

  // Register map
  localparam logic [TtiAddrWidth-1:0] TtiAddrRxDesc   = 3'd0;  // Read pops the RX descriptor queue
  localparam logic [TtiAddrWidth-1:0] TtiAddrRxData   = 3'd1;  // Read pops the RX data queue
  localparam logic [TtiAddrWidth-1:0] TtiAddrTxDesc   = 3'd2;  // Write pushes the TX descriptor queue
  localparam logic [TtiAddrWidth-1:0] TtiAddrTxData   = 3'd3;  // Write pushes the TX data queue
  localparam logic [TtiAddrWidth-1:0] TtiAddrThldCtrl = 3'd4;
  localparam logic [TtiAddrWidth-1:0] TtiAddrStatus   = 3'd5;

  // Status bits that the controller looks at before popping an RX queue.
  // Each queue owns three bits (full, empty, ready trigger), RX descriptors first
  localparam int unsigned TtiStatRxDescEmpty = 1;
  localparam int unsigned TtiStatRxDataEmpty = 4;

  // Threshold control register, seen either as one raw word or as its four fields.
  // A packed struct lists the most significant field first
  typedef union packed {
    logic [TtiDataWidth-1:0] raw;
    struct packed {
      logic [TtiThldWidth-1:0] tx_data_thld;  // Bits 31:24
      logic [TtiThldWidth-1:0] rx_data_thld;  // Bits 23:16
      logic [TtiThldWidth-1:0] tx_desc_thld;  // Bits 15:8
      logic [TtiThldWidth-1:0] rx_desc_thld;  // Bits 7:0
    } fields;
  } tti_thld_ctrl_t;

endpackage

//--- tti_queue.sv
// Circular buffer used for all four TTI queues, with occupancy count and threshold triggers.
// IS_TX picks the TX trigger rules (free space based) instead of the RX rules.
`timescale 1ns/1ps

module tti_queue #(
  parameter int unsigned DEPTH = 8,
  parameter bit          IS_TX = 1'b0
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  logic                              push_i,
  input  logic                              pop_i,
  input  logic [tti_pkg::TtiDataWidth-1:0]  wdata_i,
  input  logic [tti_pkg::TtiThldWidth-1:0]  thld_i,

  output logic [tti_pkg::TtiDataWidth-1:0]  rdata_o,
  output logic                              full_o,
  output logic                              empty_o,
  output logic                              ready_trig_o,
  output logic                              start_trig_o
);
  import tti_pkg::*;

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);
  // Comparisons run at a width that holds both the count and a threshold
  localparam int unsigned CmpW = (CntW > TtiThldWidth) ? CntW : TtiThldWidth;
  localparam logic [PtrW-1:0] LastPtr = PtrW'(DEPTH - 1);

  logic [TtiDataWidth-1:0] mem_q [DEPTH];
  logic [PtrW-1:0]         wr_ptr_q;
  logic [PtrW-1:0]         rd_ptr_q;
  logic [CntW-1:0]         count_q;

  logic                    push_ok;
  logic                    pop_ok;

  logic [CmpW-1:0]         occupancy;
  logic [CmpW-1:0]         free_space;
  logic [CmpW-1:0]         thld;

  assign full_o  = (count_q == CntW'(DEPTH));
  assign empty_o = (count_q == '0);

  // Pushing into a full queue or popping an empty one has no effect
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  // The head word is always shown, so a TX consumer sees it together with valid
  assign rdata_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;  // Wraps for any depth
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // A push and a pop in the same cycle leave the count unchanged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign occupancy  = CmpW'(count_q);
  assign free_space = CmpW'(DEPTH) - occupancy;
  assign thld       = CmpW'(thld_i);

  // Triggers follow the occupancy and the applied threshold without a register.
  // A zero threshold keeps both triggers low
  always_comb begin
    ready_trig_o = 1'b0;
    start_trig_o = 1'b0;
    if (thld != '0) begin
      if (IS_TX) begin
        ready_trig_o = (free_space >= thld);  // Room for another block from software
        start_trig_o = (occupancy >= thld);   // Enough data queued to start sending
      end else begin
        ready_trig_o = (occupancy >= thld);
        // Data has started to arrive but has not reached the threshold yet
        start_trig_o = (occupancy != '0) && (occupancy < thld);
      end
    end
  end

endmodule

//--- tti_ctrl.sv
// Register port of the TTI block: decodes accesses, issues queue strobes and holds thresholds.
// Software writes to the threshold register reach the queues through a two-stage update.
`timescale 1ns/1ps

module tti_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  input  logic                               csr_req_i,
  input  logic                               csr_we_i,
  input  logic [tti_pkg::TtiAddrWidth-1:0]   csr_addr_i,
  input  logic [tti_pkg::TtiDataWidth-1:0]   csr_wdata_i,
  output logic                               csr_ack_o,
  output logic [tti_pkg::TtiDataWidth-1:0]   csr_rdata_o,

  output logic                               rx_desc_pop_o,
  output logic                               rx_data_pop_o,
  output logic                               tx_desc_push_o,
  output logic                               tx_data_push_o,

  input  logic [tti_pkg::TtiDataWidth-1:0]   rx_desc_rdata_i,
  input  logic [tti_pkg::TtiDataWidth-1:0]   rx_data_rdata_i,

  input  logic [tti_pkg::TtiStatusWidth-1:0] status_i,

  output logic [tti_pkg::TtiThldWidth-1:0]   rx_desc_thld_o,
  output logic [tti_pkg::TtiThldWidth-1:0]   tx_desc_thld_o,
  output logic [tti_pkg::TtiThldWidth-1:0]   rx_data_thld_o,
  output logic [tti_pkg::TtiThldWidth-1:0]   tx_data_thld_o
);
  import tti_pkg::*;

  logic                    req_take;
  logic                    rd_take;
  logic                    wr_take;
  logic                    ack_q;

  logic                    rx_desc_empty;
  logic                    rx_data_empty;

  logic [TtiDataWidth-1:0] rdata_d;
  logic [TtiDataWidth-1:0] rdata_q;

  tti_thld_ctrl_t          thld_q;          // Software view, read back at once
  tti_thld_ctrl_t          thld_applied_q;  // Value the queues work with
  logic                    thld_swmod;
  logic                    thld_swmod_q;
  logic                    thld_we_q;

  // A new request is only accepted while no acknowledge is outstanding
  assign req_take = csr_req_i && !ack_q;
  assign rd_take  = req_take && !csr_we_i;
  assign wr_take  = req_take && csr_we_i;

  assign rx_desc_empty = status_i[TtiStatRxDescEmpty];
  assign rx_data_empty = status_i[TtiStatRxDataEmpty];

  // Strobes fire in the request cycle so the queue moves on the edge that raises the ack.
  // An empty RX queue gets no pop at all
  assign rx_desc_pop_o  = rd_take && (csr_addr_i == TtiAddrRxDesc) && !rx_desc_empty;
  assign rx_data_pop_o  = rd_take && (csr_addr_i == TtiAddrRxData) && !rx_data_empty;
  assign tx_desc_push_o = wr_take && (csr_addr_i == TtiAddrTxDesc);  // Full queue drops it
  assign tx_data_push_o = wr_take && (csr_addr_i == TtiAddrTxData);

  assign thld_swmod = wr_take && (csr_addr_i == TtiAddrThldCtrl);

  // Read data mux, sampled together with the head word being popped
  always_comb begin
    rdata_d = '0;
    if (rd_take) begin
      case (csr_addr_i)
        TtiAddrRxDesc: begin
          if (!rx_desc_empty) rdata_d = rx_desc_rdata_i;
        end
        TtiAddrRxData: begin
          if (!rx_data_empty) rdata_d = rx_data_rdata_i;
        end
        TtiAddrThldCtrl: rdata_d = thld_q.raw;
        TtiAddrStatus:   rdata_d = TtiDataWidth'(status_i);  // Upper bits read as zero
        default:         rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_take;  // One cycle pulse, the next request waits for it to drop
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_take) begin
      rdata_q <= rdata_d;
    end
  end

  assign csr_ack_o   = ack_q;
  assign csr_rdata_o = rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      thld_q <= '0;
    end else if (thld_swmod) begin
      thld_q.raw <= csr_wdata_i;
    end
  end

  // The modified flag passes two flops before the applied copy is loaded.
  // New thresholds reach the triggers two cycles after the acknowledge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      thld_swmod_q   <= 1'b0;
      thld_we_q      <= 1'b0;
      thld_applied_q <= '0;
    end else begin
      thld_swmod_q <= thld_swmod;
      thld_we_q    <= thld_swmod_q;
      if (thld_we_q) begin
        thld_applied_q <= thld_q;
      end
    end
  end

  assign rx_desc_thld_o = thld_applied_q.fields.rx_desc_thld;
  assign tx_desc_thld_o = thld_applied_q.fields.tx_desc_thld;
  assign rx_data_thld_o = thld_applied_q.fields.rx_data_thld;
  assign tx_data_thld_o = thld_applied_q.fields.tx_data_thld;

endmodule

//--- tti_top.sv
// Top level of the TTI block: register controller plus RX and TX descriptor and data queues.
// The target engine talks to the queues through valid/ready pairs.
`timescale 1ns/1ps

module tti_top #(
  parameter int unsigned RX_DESC_DEPTH = 4,
  parameter int unsigned TX_DESC_DEPTH = 4,
  parameter int unsigned RX_DATA_DEPTH = 8,
  parameter int unsigned TX_DATA_DEPTH = 8
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Register bus
  input  logic                             csr_req_i,
  input  logic                             csr_we_i,
  input  logic [tti_pkg::TtiAddrWidth-1:0] csr_addr_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] csr_wdata_i,
  output logic                             csr_ack_o,
  output logic [tti_pkg::TtiDataWidth-1:0] csr_rdata_o,

  // RX descriptor queue, filled by the target engine
  input  logic                             rx_desc_wvalid_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] rx_desc_wdata_i,
  output logic                             rx_desc_wready_o,
  output logic                             rx_desc_full_o,
  output logic                             rx_desc_empty_o,
  output logic                             rx_desc_ready_thld_trig_o,

  // RX data queue
  input  logic                             rx_data_wvalid_i,
  input  logic [tti_pkg::TtiDataWidth-1:0] rx_data_wdata_i,
  output logic                             rx_data_wready_o,
  output logic                             rx_data_full_o,
  output logic                             rx_data_empty_o,
  output logic                             rx_data_ready_thld_trig_o,
  output logic                             rx_data_start_thld_trig_o,

  // TX descriptor queue, drained by the target engine
  output logic                             tx_desc_rvalid_o,
  output logic [tti_pkg::TtiDataWidth-1:0] tx_desc_rdata_o,
  input  logic                             tx_desc_rready_i,
  output logic                             tx_desc_full_o,
  output logic                             tx_desc_empty_o,
  output logic                             tx_desc_ready_thld_trig_o,

  // TX data queue
  output logic                             tx_data_rvalid_o,
  output logic [tti_pkg::TtiDataWidth-1:0] tx_data_rdata_o,
  input  logic                             tx_data_rready_i,
  output logic                             tx_data_full_o,
  output logic                             tx_data_empty_o,
  output logic                             tx_data_ready_thld_trig_o,
  output logic                             tx_data_start_thld_trig_o
);
  import tti_pkg::*;

  logic                      rx_desc_pop;
  logic                      rx_data_pop;
  logic                      tx_desc_push;
  logic                      tx_data_push;
  logic [TtiDataWidth-1:0]   rx_desc_rdata;
  logic [TtiDataWidth-1:0]   rx_data_rdata;
  logic [TtiThldWidth-1:0]   rx_desc_thld;
  logic [TtiThldWidth-1:0]   tx_desc_thld;
  logic [TtiThldWidth-1:0]   rx_data_thld;
  logic [TtiThldWidth-1:0]   tx_data_thld;
  logic [TtiStatusWidth-1:0] status;

  assign rx_desc_wready_o = !rx_desc_full_o;
  assign rx_data_wready_o = !rx_data_full_o;
  assign tx_desc_rvalid_o = !tx_desc_empty_o;
  assign tx_data_rvalid_o = !tx_data_empty_o;

  // Status word, three flags per queue from bit 0, then the two start triggers
  assign status = {tx_data_start_thld_trig_o, rx_data_start_thld_trig_o,
                   tx_data_ready_thld_trig_o, tx_data_empty_o, tx_data_full_o,
                   tx_desc_ready_thld_trig_o, tx_desc_empty_o, tx_desc_full_o,
                   rx_data_ready_thld_trig_o, rx_data_empty_o, rx_data_full_o,
                   rx_desc_ready_thld_trig_o, rx_desc_empty_o, rx_desc_full_o};

  tti_ctrl u_ctrl (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_we_i,
    .csr_addr_i,
    .csr_wdata_i,
    .csr_ack_o,
    .csr_rdata_o,
    .rx_desc_pop_o   (rx_desc_pop),
    .rx_data_pop_o   (rx_data_pop),
    .tx_desc_push_o  (tx_desc_push),
    .tx_data_push_o  (tx_data_push),
    .rx_desc_rdata_i (rx_desc_rdata),
    .rx_data_rdata_i (rx_data_rdata),
    .status_i        (status),
    .rx_desc_thld_o  (rx_desc_thld),
    .tx_desc_thld_o  (tx_desc_thld),
    .rx_data_thld_o  (rx_data_thld),
    .tx_data_thld_o  (tx_data_thld)
  );

  tti_queue #(.DEPTH(RX_DESC_DEPTH), .IS_TX(1'b0)) u_rx_desc_q (
    .clk_i,
    .rst_ni,
    .push_i       (rx_desc_wvalid_i && rx_desc_wready_o),
    .pop_i        (rx_desc_pop),
    .wdata_i      (rx_desc_wdata_i),
    .thld_i       (rx_desc_thld),
    .rdata_o      (rx_desc_rdata),
    .full_o       (rx_desc_full_o),
    .empty_o      (rx_desc_empty_o),
    .ready_trig_o (rx_desc_ready_thld_trig_o),
    .start_trig_o ()  // Descriptor queues have no start threshold
  );

  tti_queue #(.DEPTH(RX_DATA_DEPTH), .IS_TX(1'b0)) u_rx_data_q (
    .clk_i,
    .rst_ni,
    .push_i       (rx_data_wvalid_i && rx_data_wready_o),
    .pop_i        (rx_data_pop),
    .wdata_i      (rx_data_wdata_i),
    .thld_i       (rx_data_thld),
    .rdata_o      (rx_data_rdata),
    .full_o       (rx_data_full_o),
    .empty_o      (rx_data_empty_o),
    .ready_trig_o (rx_data_ready_thld_trig_o),
    .start_trig_o (rx_data_start_thld_trig_o)
  );

  // TX queues take their words straight from the bus in the request cycle
  tti_queue #(.DEPTH(TX_DESC_DEPTH), .IS_TX(1'b1)) u_tx_desc_q (
    .clk_i,
    .rst_ni,
    .push_i       (tx_desc_push),
    .pop_i        (tx_desc_rvalid_o && tx_desc_rready_i),
    .wdata_i      (csr_wdata_i),
    .thld_i       (tx_desc_thld),
    .rdata_o      (tx_desc_rdata_o),
    .full_o       (tx_desc_full_o),
    .empty_o      (tx_desc_empty_o),
    .ready_trig_o (tx_desc_ready_thld_trig_o),
    .start_trig_o ()
  );

  tti_queue #(.DEPTH(TX_DATA_DEPTH), .IS_TX(1'b1)) u_tx_data_q (
    .clk_i,
    .rst_ni,
    .push_i       (tx_data_push),
    .pop_i        (tx_data_rvalid_o && tx_data_rready_i),
    .wdata_i      (csr_wdata_i),
    .thld_i       (tx_data_thld),
    .rdata_o      (tx_data_rdata_o),
    .full_o       (tx_data_full_o),
    .empty_o      (tx_data_empty_o),
    .ready_trig_o (tx_data_ready_thld_trig_o),
    .start_trig_o (tx_data_start_thld_trig_o)
  );

endmodule

//--- tb_tti_top.sv
// Table-driven testbench for the TTI block with reference queue models.
// Each table entry runs a register access or a target-side push or pop, then checks all flags.
`timescale 1ns/1ps

module tb_tti_top;
  import tti_pkg::*;

  localparam logic [3:0] KRxPush = 4'd0;
  localparam logic [3:0] KRead   = 4'd1;
  localparam logic [3:0] KWrite  = 4'd2;
  localparam logic [3:0] KTxPop  = 4'd3;
  localparam int Timeout = 100;

  typedef struct packed {
    logic [3:0]              kind;
    logic [TtiAddrWidth-1:0] addr;  // Register address, or queue index for target-side entries
    logic [31:0]             arg;   // Write data for ThldCtrl, stall cycles for a TX pop
    logic [31:0]             exp;   // Read data for addresses without a model
    logic [7:0]              reps;
  } op_t;

  localparam int NumOps = 25;
  localparam op_t OpTable [NumOps] = '{
    '{KRead,   3'd5, 32'd0, 32'd0, 8'd1},          // Reset state
    '{KRxPush, 3'd0, 32'd0, 32'd0, 8'd3},
    '{KRxPush, 3'd1, 32'd0, 32'd0, 8'd3},
    '{KRead,   3'd0, 32'd0, 32'd0, 8'd4},          // Last read finds the queue empty
    '{KRead,   3'd1, 32'd0, 32'd0, 8'd4},
    '{KWrite,  3'd4, 32'h04030202, 32'd0, 8'd1},
    '{KRxPush, 3'd0, 32'd0, 32'd0, 8'd5},          // Fifth push is refused
    '{KRead,   3'd5, 32'd0, 32'd0, 8'd1},
    '{KRxPush, 3'd1, 32'd0, 32'd0, 8'd4},
    '{KRead,   3'd1, 32'd0, 32'd0, 8'd4},
    '{KRead,   3'd0, 32'd0, 32'd0, 8'd4},
    '{KWrite,  3'd2, 32'd0, 32'd0, 8'd5},          // Fifth write is dropped
    '{KWrite,  3'd3, 32'd0, 32'd0, 8'd9},
    '{KRead,   3'd5, 32'd0, 32'd0, 8'd1},
    '{KTxPop,  3'd2, 32'd3, 32'd0, 8'd1},
    '{KTxPop,  3'd2, 32'd0, 32'd0, 8'd4},
    '{KTxPop,  3'd3, 32'd2, 32'd0, 8'd5},
    '{KRead,   3'd5, 32'd0, 32'd0, 8'd1},
    '{KTxPop,  3'd3, 32'd0, 32'd0, 8'd4},
    '{KWrite,  3'd4, 32'h00000000, 32'd0, 8'd1},   // All triggers off
    '{KRxPush, 3'd1, 32'd0, 32'd0, 8'd2},
    '{KRead,   3'd5, 32'd0, 32'd0, 8'd1},
    '{KRead,   3'd1, 32'd0, 32'd0, 8'd2},
    '{KRead,   3'd6, 32'd0, 32'd0, 8'd1},          // Unmapped address
    '{KRead,   3'd7, 32'd0, 32'd0, 8'd1}
  };

  logic clk_i = 1'b0;
  logic rst_ni;
  logic csr_req_i;
  logic csr_we_i;
  logic [TtiAddrWidth-1:0] csr_addr_i;
  logic [TtiDataWidth-1:0] csr_wdata_i;
  logic csr_ack_o;
  logic [TtiDataWidth-1:0] csr_rdata_o;
  logic rx_desc_wvalid_i, rx_data_wvalid_i, tx_desc_rready_i, tx_data_rready_i;
  logic [TtiDataWidth-1:0] rx_desc_wdata_i, rx_data_wdata_i, tx_desc_rdata_o, tx_data_rdata_o;
  logic rx_desc_wready_o, rx_desc_full_o, rx_desc_empty_o, rx_desc_ready_thld_trig_o;
  logic rx_data_wready_o, rx_data_full_o, rx_data_empty_o, rx_data_ready_thld_trig_o;
  logic rx_data_start_thld_trig_o;
  logic tx_desc_rvalid_o, tx_desc_full_o, tx_desc_empty_o, tx_desc_ready_thld_trig_o;
  logic tx_data_rvalid_o, tx_data_full_o, tx_data_empty_o, tx_data_ready_thld_trig_o;
  logic tx_data_start_thld_trig_o;
  logic [TtiStatusWidth-1:0] dut_flags;

  logic [TtiDataWidth-1:0] model_q [4][$];  // Indexed like the queue addresses
  int unsigned             depth [4] = '{4, 8, 4, 8};
  tti_thld_ctrl_t          thld_sw;
  tti_thld_ctrl_t          thld_applied;

  // Port names of the status flags in status bit order
  string flag_names [TtiStatusWidth] = '{
    "rx_desc_full_o", "rx_desc_empty_o", "rx_desc_ready_thld_trig_o",
    "rx_data_full_o", "rx_data_empty_o", "rx_data_ready_thld_trig_o",
    "tx_desc_full_o", "tx_desc_empty_o", "tx_desc_ready_thld_trig_o",
    "tx_data_full_o", "tx_data_empty_o", "tx_data_ready_thld_trig_o",
    "rx_data_start_thld_trig_o", "tx_data_start_thld_trig_o"
  };

  always #10 clk_i = ~clk_i;

  assign dut_flags = {tx_data_start_thld_trig_o, rx_data_start_thld_trig_o,
                      tx_data_ready_thld_trig_o, tx_data_empty_o, tx_data_full_o,
                      tx_desc_ready_thld_trig_o, tx_desc_empty_o, tx_desc_full_o,
                      rx_data_ready_thld_trig_o, rx_data_empty_o, rx_data_full_o,
                      rx_desc_ready_thld_trig_o, rx_desc_empty_o, rx_desc_full_o};

  tti_top dut (.*);

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [TtiDataWidth-1:0] got,
                            input logic [TtiDataWidth-1:0] exp);
    if (got !== exp) fail_now($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_thld(input string name, input tti_thld_ctrl_t got,
                            input tti_thld_ctrl_t exp);
    if (got !== exp) fail_now($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
  endtask

  function automatic logic [7:0] thld_of(input int q);
    case (q)
      0:       return thld_applied.fields.rx_desc_thld;
      1:       return thld_applied.fields.rx_data_thld;
      2:       return thld_applied.fields.tx_desc_thld;
      default: return thld_applied.fields.tx_data_thld;
    endcase
  endfunction

  // Status expected from the model occupancy and the applied thresholds
  function automatic logic [TtiStatusWidth-1:0] exp_status();
    logic [TtiStatusWidth-1:0] s;
    int unsigned cnt;
    int unsigned th;
    s = '0;
    for (int q = 0; q < 4; q++) begin
      cnt = model_q[q].size();
      th  = 32'(thld_of(q));
      s[3*q]   = (cnt == depth[q]);
      s[3*q+1] = (cnt == 0);
      if (th != 0) begin
        s[3*q+2] = (q >= 2) ? ((depth[q] - cnt) >= th) : (cnt >= th);
        if (q == 1) s[12] = (cnt != 0) && (cnt < th);
        if (q == 3) s[13] = (cnt >= th);
      end
    end
    return s;
  endfunction

  task automatic check_state();
    logic [TtiStatusWidth-1:0] exp;
    exp = exp_status();
    for (int b = 0; b < TtiStatusWidth; b++) begin
      check_flag(flag_names[b], dut_flags[b], exp[b]);
    end
    check_flag("rx_desc_wready_o", rx_desc_wready_o, !exp[0]);
    check_flag("rx_data_wready_o", rx_data_wready_o, !exp[3]);
    check_flag("tx_desc_rvalid_o", tx_desc_rvalid_o, !exp[7]);
    check_flag("tx_data_rvalid_o", tx_data_rvalid_o, !exp[10]);
    check_flag("csr_ack_o", csr_ack_o, 1'b0);
  endtask

  task automatic csr_access(input logic we, input logic [TtiAddrWidth-1:0] addr,
                            input logic [TtiDataWidth-1:0] wdata,
                            output logic [TtiDataWidth-1:0] rdata);
    int n;
    @(posedge clk_i);
    csr_req_i   <= 1'b1;
    csr_we_i    <= we;
    csr_addr_i  <= addr;
    csr_wdata_i <= wdata;
    @(posedge clk_i);
    csr_req_i <= 1'b0;
    n = 0;
    @(negedge clk_i);
    while (!csr_ack_o) begin
      n++;
      if (n > Timeout) fail_now("No acknowledge came back for a register access");
      @(negedge clk_i);
    end
    rdata = csr_rdata_o;
    @(negedge clk_i);  // Ack must be a single cycle pulse
  endtask

  task automatic rx_push(input logic [TtiAddrWidth-1:0] q);
    logic [TtiDataWidth-1:0] w;
    w = $urandom();
    @(posedge clk_i);
    if (q == TtiAddrRxDesc) begin
      rx_desc_wvalid_i <= 1'b1;
      rx_desc_wdata_i  <= w;
    end else begin
      rx_data_wvalid_i <= 1'b1;
      rx_data_wdata_i  <= w;
    end
    @(negedge clk_i);
    check_flag((q == TtiAddrRxDesc) ? "rx_desc_wready_o" : "rx_data_wready_o",
               (q == TtiAddrRxDesc) ? rx_desc_wready_o : rx_data_wready_o,
               model_q[q].size() < depth[q]);
    @(posedge clk_i);
    rx_desc_wvalid_i <= 1'b0;
    rx_data_wvalid_i <= 1'b0;
    if (model_q[q].size() < depth[q]) model_q[q].push_back(w);
    @(negedge clk_i);
  endtask

  task automatic tx_pop(input logic [TtiAddrWidth-1:0] q, input int stall);
    logic [TtiDataWidth-1:0] head;
    int n;
    @(negedge clk_i);
    if (model_q[q].size() == 0) begin
      check_flag((q == TtiAddrTxDesc) ? "tx_desc_rvalid_o" : "tx_data_rvalid_o",
                 (q == TtiAddrTxDesc) ? tx_desc_rvalid_o : tx_data_rvalid_o, 1'b0);
    end else begin
      n = 0;
      while (!((q == TtiAddrTxDesc) ? tx_desc_rvalid_o : tx_data_rvalid_o)) begin
        n++;
        if (n > Timeout) fail_now("TX queue never showed a valid head word");
        @(negedge clk_i);
      end
      for (int s = 0; s <= stall; s++) begin  // Head must hold while rready stays low
        head = (q == TtiAddrTxDesc) ? tx_desc_rdata_o : tx_data_rdata_o;
        check_word((q == TtiAddrTxDesc) ? "tx_desc_rdata_o" : "tx_data_rdata_o",
                   head, model_q[q][0]);
        @(negedge clk_i);
      end
      @(posedge clk_i);
      if (q == TtiAddrTxDesc) tx_desc_rready_i <= 1'b1;
      else tx_data_rready_i <= 1'b1;
      @(posedge clk_i);
      tx_desc_rready_i <= 1'b0;
      tx_data_rready_i <= 1'b0;
      void'(model_q[q].pop_front());
      @(negedge clk_i);
    end
  endtask

  initial begin
    logic [TtiDataWidth-1:0] rd;
    logic [TtiDataWidth-1:0] exp;
    op_t op;
    void'($urandom(5767));
    rst_ni = 1'b0;
    csr_req_i = 1'b0;
    csr_we_i = 1'b0;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    rx_desc_wvalid_i = 1'b0;
    rx_data_wvalid_i = 1'b0;
    rx_desc_wdata_i = '0;
    rx_data_wdata_i = '0;
    tx_desc_rready_i = 1'b0;
    tx_data_rready_i = 1'b0;
    thld_sw = '0;
    thld_applied = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_state();

    for (int i = 0; i < NumOps; i++) begin
      op = OpTable[i];
      for (int r = 0; r < int'(op.reps); r++) begin
        case (op.kind)
          KRxPush: rx_push(op.addr);
          KTxPop:  tx_pop(op.addr, op.arg);
          KRead: begin
            if (op.addr <= 3'd1) begin
              exp = (model_q[op.addr].size() != 0) ? model_q[op.addr].pop_front() : '0;
            end else if (op.addr == TtiAddrStatus) begin
              exp = TtiDataWidth'(exp_status());
            end else begin
              exp = op.exp;
            end
            csr_access(1'b0, op.addr, '0, rd);
            check_word("csr_rdata_o", rd, exp);
          end
          default: begin
            if (op.addr == TtiAddrThldCtrl) begin
              csr_access(1'b1, op.addr, op.arg, rd);
              thld_sw.raw = op.arg;
              check_state();          // Triggers still follow the old thresholds
              @(posedge clk_i);       // Second edge after the acknowledge loads the queues
              thld_applied = thld_sw;
              @(negedge clk_i);
              check_state();
              csr_access(1'b0, op.addr, '0, rd);
              check_thld("csr_rdata_o", rd, thld_sw);
            end else begin
              exp = $urandom();
              csr_access(1'b1, op.addr, exp, rd);
              if (model_q[op.addr].size() < depth[op.addr]) model_q[op.addr].push_back(exp);
            end
          end
        endcase
        check_state();
      end
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- tti_top.f
tti_pkg.sv
tti_queue.sv
tti_ctrl.sv
tti_top.sv
tb_tti_top.sv

//--- Makefile
VERILATOR   ?= verilator
FLAGS       ?= --binary --timing -j 0
LINT_FLAGS  ?= --lint-only
TOP         ?= tb_tti_top
RTL_TOP     ?= tti_top
FILELIST    ?= tti_top.f
RTL_FILES   ?= tti_pkg.sv tti_queue.sv tti_ctrl.sv tti_top.sv
LOG         ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

obj_dir/V$(TOP): $(RTL_FILES) tb_tti_top.sv $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
